/* dtw_pkg.sv */
`default_nettype none

package dtw_pkg;

	// ----------------------------------------
	// AXI4-Lite bus geometry
	// ----------------------------------------
	localparam int DATA_W = 32;
	localparam int ADDR_W = 5;
	// Byte offset inside one 32-bit word
	localparam int ADDR_LSB = 2;
	// Word index width, eight registers
	localparam int REG_IDX_W = ADDR_W - ADDR_LSB;

	// ----------------------------------------
	// Datapath widths
	// ----------------------------------------
	// Unsigned samples
	localparam int SAMPLE_W = 8;
	// Worst path is 31 steps of 255
	localparam int DIST_W = 16;
	// Default depth of each sample buffer
	localparam int DEF_MAX_LEN = 16;

	// ----------------------------------------
	// Register map, word indices
	// ----------------------------------------
	localparam logic [REG_IDX_W-1:0] REG_CTRL     = REG_IDX_W'(0);
	localparam logic [REG_IDX_W-1:0] REG_STATUS   = REG_IDX_W'(1);
	localparam logic [REG_IDX_W-1:0] REG_REF_LEN  = REG_IDX_W'(2);
	localparam logic [REG_IDX_W-1:0] REG_QRY_LEN  = REG_IDX_W'(3);
	localparam logic [REG_IDX_W-1:0] REG_REF_PUSH = REG_IDX_W'(4);
	localparam logic [REG_IDX_W-1:0] REG_QRY_PUSH = REG_IDX_W'(5);
	localparam logic [REG_IDX_W-1:0] REG_DIST     = REG_IDX_W'(6);
	// Index 7 reserved, reads zero

	// Control register bits, both self-clearing
	localparam int CTRL_START_BIT = 0;
	localparam int CTRL_CLEAR_BIT = 1;

	// Status register bits
	localparam int STAT_BUSY_BIT = 0;
	localparam int STAT_DONE_BIT = 1;
	localparam int STAT_ERR_BIT  = 2;

endpackage

`default_nettype wire

/* dtw_axi_regs.sv */
`default_nettype none

module dtw_axi_regs import dtw_pkg::*; #(
	parameter int MAX_LEN = DEF_MAX_LEN
) (
	input  logic                  S_AXI_ACLK,
	input  logic                  S_AXI_ARESETN,
	input  logic [ADDR_W-1:0]     S_AXI_AWADDR,
	input  logic [2:0]            S_AXI_AWPROT,
	input  logic                  S_AXI_AWVALID,
	output logic                  S_AXI_AWREADY,
	input  logic [DATA_W-1:0]     S_AXI_WDATA,
	input  logic [DATA_W/8-1:0]   S_AXI_WSTRB,
	input  logic                  S_AXI_WVALID,
	output logic                  S_AXI_WREADY,
	output logic [1:0]            S_AXI_BRESP,
	output logic                  S_AXI_BVALID,
	input  logic                  S_AXI_BREADY,
	input  logic [ADDR_W-1:0]     S_AXI_ARADDR,
	input  logic [2:0]            S_AXI_ARPROT,
	input  logic                  S_AXI_ARVALID,
	output logic                  S_AXI_ARREADY,
	output logic [DATA_W-1:0]     S_AXI_RDATA,
	output logic [1:0]            S_AXI_RRESP,
	output logic                  S_AXI_RVALID,
	input  logic                  S_AXI_RREADY,
	// Core levels
	input  logic                  busy,
	input  logic                  done,
	input  logic                  err,
	input  logic [DIST_W-1:0]     distance,
	// Core and buffer controls
	output logic                  start,
	output logic                  clear,
	output logic                  ref_push,
	output logic                  qry_push,
	output logic [SAMPLE_W-1:0]   push_data,
	output logic [DATA_W-1:0]     ref_len,
	output logic [DATA_W-1:0]     qry_len
);

	// Bits of REG_CTRL that only live for one cycle
	localparam logic [DATA_W-1:0] CTRL_PULSE_MASK =
		(DATA_W'(1) << CTRL_START_BIT) | (DATA_W'(1) << CTRL_CLEAR_BIT);

	logic [ADDR_W-1:0]    aw_addr;
	logic [ADDR_W-1:0]    ar_addr;
	logic                 aw_en;
	logic                 wr_en;
	logic                 rd_en;
	logic [DATA_W-1:0]    ctrl_reg;
	logic [DATA_W-1:0]    rd_mux;

	// Always OKAY, no error responses
	assign S_AXI_BRESP = 2'b00;
	assign S_AXI_RRESP = 2'b00;

	// ----------------------------------------
	// Write address and data acceptance
	// ----------------------------------------
	// Both ready lines pulse together, one write in flight
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			S_AXI_AWREADY <= 1'b0;
			S_AXI_WREADY  <= 1'b0;
			aw_en         <= 1'b1;
		end else if (!S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WVALID && aw_en) begin
			S_AXI_AWREADY <= 1'b1;
			S_AXI_WREADY  <= 1'b1;
			aw_en         <= 1'b0;
			aw_addr       <= S_AXI_AWADDR;
		end else begin
			S_AXI_AWREADY <= 1'b0;
			S_AXI_WREADY  <= 1'b0;
			// Reopen only once the response is taken
			if (S_AXI_BVALID && S_AXI_BREADY)
				aw_en <= 1'b1;
		end
	end

	assign wr_en = S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WREADY && S_AXI_WVALID;

	// Write response, held until BREADY
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN)
			S_AXI_BVALID <= 1'b0;
		else if (wr_en && !S_AXI_BVALID)
			S_AXI_BVALID <= 1'b1;
		else if (S_AXI_BREADY)
			S_AXI_BVALID <= 1'b0;
	end

	// ----------------------------------------
	// Register file and strobes
	// ----------------------------------------
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			ctrl_reg <= '0;
			ref_len  <= DATA_W'(MAX_LEN);
			qry_len  <= DATA_W'(MAX_LEN);
			ref_push <= 1'b0;
			qry_push <= 1'b0;
		end else begin
			// Start and clear drop after one cycle
			ctrl_reg[CTRL_START_BIT] <= 1'b0;
			ctrl_reg[CTRL_CLEAR_BIT] <= 1'b0;
			ref_push <= 1'b0;
			qry_push <= 1'b0;
			if (wr_en) begin
				case (aw_addr[ADDR_W-1:ADDR_LSB])
					REG_CTRL:
						for (int b = 0; b < DATA_W/8; b++)
							if (S_AXI_WSTRB[b])
								ctrl_reg[b*8 +: 8] <= S_AXI_WDATA[b*8 +: 8];
					REG_REF_LEN:
						for (int b = 0; b < DATA_W/8; b++)
							if (S_AXI_WSTRB[b])
								ref_len[b*8 +: 8] <= S_AXI_WDATA[b*8 +: 8];
					REG_QRY_LEN:
						for (int b = 0; b < DATA_W/8; b++)
							if (S_AXI_WSTRB[b])
								qry_len[b*8 +: 8] <= S_AXI_WDATA[b*8 +: 8];
					// Sample push needs byte lane 0
					REG_REF_PUSH: ref_push <= S_AXI_WSTRB[0];
					REG_QRY_PUSH: qry_push <= S_AXI_WSTRB[0];
					default: ;
				endcase
			end
		end
	end

	// Low byte of the write data feeds both buffers
	always_ff @(posedge S_AXI_ACLK) begin
		if (wr_en && S_AXI_WSTRB[0])
			push_data <= S_AXI_WDATA[SAMPLE_W-1:0];
	end

	assign start = ctrl_reg[CTRL_START_BIT];
	assign clear = ctrl_reg[CTRL_CLEAR_BIT];

	// ----------------------------------------
	// Read address and data
	// ----------------------------------------
	// No new address while read data waits
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			S_AXI_ARREADY <= 1'b0;
		end else if (!S_AXI_ARREADY && S_AXI_ARVALID && !S_AXI_RVALID) begin
			S_AXI_ARREADY <= 1'b1;
			ar_addr       <= S_AXI_ARADDR;
		end else begin
			S_AXI_ARREADY <= 1'b0;
		end
	end

	assign rd_en = S_AXI_ARREADY && S_AXI_ARVALID && !S_AXI_RVALID;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN)
			S_AXI_RVALID <= 1'b0;
		else if (rd_en)
			S_AXI_RVALID <= 1'b1;
		else if (S_AXI_RREADY)
			S_AXI_RVALID <= 1'b0;
	end

	// Status and distance come straight from the core
	always_comb begin
		rd_mux = '0;
		case (ar_addr[ADDR_W-1:ADDR_LSB])
			REG_CTRL:    rd_mux = ctrl_reg & ~CTRL_PULSE_MASK;
			REG_STATUS: begin
				rd_mux[STAT_BUSY_BIT] = busy;
				rd_mux[STAT_DONE_BIT] = done;
				rd_mux[STAT_ERR_BIT]  = err;
			end
			REG_REF_LEN: rd_mux = ref_len;
			REG_QRY_LEN: rd_mux = qry_len;
			REG_DIST:    rd_mux = DATA_W'(distance);
			// Push and reserved words read zero
			default:     rd_mux = '0;
		endcase
	end

	// Data frozen while RVALID is up
	always_ff @(posedge S_AXI_ACLK) begin
		if (rd_en)
			S_AXI_RDATA <= rd_mux;
	end

endmodule

`default_nettype wire

/* dtw_sample_buf.sv */
`default_nettype none

module dtw_sample_buf import dtw_pkg::*; #(
	parameter int MAX_LEN = DEF_MAX_LEN
) (
	input  logic                               S_AXI_ACLK,
	input  logic                               S_AXI_ARESETN,
	input  logic                               clear,
	input  logic                               push,
	input  logic [SAMPLE_W-1:0]                push_data,
	input  logic [((MAX_LEN > 1) ? $clog2(MAX_LEN) : 1)-1:0] rd_addr,
	output logic [SAMPLE_W-1:0]                rd_sample
);

	localparam int IDX_W = (MAX_LEN > 1) ? $clog2(MAX_LEN) : 1;
	// Pointer must reach MAX_LEN itself when full
	localparam int PTR_W = $clog2(MAX_LEN + 1);

	logic [SAMPLE_W-1:0] mem [MAX_LEN];
	logic [PTR_W-1:0]    wr_ptr;
	logic                wr_ok;

	// Pushes past the end are dropped
	assign wr_ok = push && !clear && (wr_ptr < PTR_W'(MAX_LEN));

	// Write pointer, back to slot 0 on clear
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN || clear)
			wr_ptr <= '0;
		else if (wr_ok)
			wr_ptr <= wr_ptr + 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (wr_ok)
			mem[wr_ptr[IDX_W-1:0]] <= push_data;
	end

	// Combinational read for the core
	assign rd_sample = mem[rd_addr];

endmodule

`default_nettype wire

/* dtw_core.sv */
`default_nettype none

module dtw_core import dtw_pkg::*; #(
	parameter int MAX_LEN = DEF_MAX_LEN
) (
	input  logic                S_AXI_ACLK,
	input  logic                S_AXI_ARESETN,
	input  logic                start,
	input  logic                clear,
	input  logic [DATA_W-1:0]   ref_len,
	input  logic [DATA_W-1:0]   qry_len,
	input  logic [SAMPLE_W-1:0] ref_sample,
	input  logic [SAMPLE_W-1:0] qry_sample,
	output logic [((MAX_LEN > 1) ? $clog2(MAX_LEN) : 1)-1:0] ref_rd_addr,
	output logic [((MAX_LEN > 1) ? $clog2(MAX_LEN) : 1)-1:0] qry_rd_addr,
	output logic                busy,
	output logic                done,
	output logic                err,
	output logic [DIST_W-1:0]   distance
);

	localparam int IDX_W = (MAX_LEN > 1) ? $clog2(MAX_LEN) : 1;
	// Stands in for cells outside the matrix
	localparam logic [DIST_W-1:0] DIST_MAX = '1;

	// Previous row of cumulative costs
	logic [DIST_W-1:0] row_buf [MAX_LEN];
	// i walks the query, j walks the reference
	logic [IDX_W-1:0]  i_idx;
	logic [IDX_W-1:0]  j_idx;
	logic [IDX_W-1:0]  ref_last;
	logic [IDX_W-1:0]  qry_last;
	logic [DIST_W-1:0] left_cost;
	logic [DIST_W-1:0] diag_cost;
	logic [DIST_W-1:0] up_cost;
	logic [DIST_W-1:0] min_cost;
	logic [DIST_W-1:0] local_cost;
	logic [DIST_W-1:0] cell_cost;
	logic              len_ok;
	logic              last_cell;
	logic              launch;

	assign len_ok = (ref_len != '0) && (ref_len <= DATA_W'(MAX_LEN)) &&
	                (qry_len != '0) && (qry_len <= DATA_W'(MAX_LEN));
	// Start while busy is ignored
	assign launch    = start && !busy;
	assign last_cell = (j_idx == ref_last) && (i_idx == qry_last);

	assign ref_rd_addr = j_idx;
	assign qry_rd_addr = i_idx;

	// ----------------------------------------
	// Cell arithmetic
	// ----------------------------------------
	always_comb begin
		// Nothing above the first row
		up_cost = (i_idx == '0) ? DIST_MAX : row_buf[j_idx];
		if (ref_sample >= qry_sample)
			local_cost = DIST_W'(ref_sample - qry_sample);
		else
			local_cost = DIST_W'(qry_sample - ref_sample);
		min_cost = (left_cost < up_cost) ? left_cost : up_cost;
		if (diag_cost < min_cost)
			min_cost = diag_cost;
		// One finite neighbour always exists, no overflow
		cell_cost = min_cost + local_cost;
	end

	// ----------------------------------------
	// Matrix walk, one cell per clock
	// ----------------------------------------
	always_ff @(posedge S_AXI_ACLK) begin
		if (launch) begin
			i_idx     <= '0;
			j_idx     <= '0;
			left_cost <= DIST_MAX;
			// Origin neighbour counts as zero
			diag_cost <= '0;
			ref_last  <= IDX_W'(ref_len - DATA_W'(1));
			qry_last  <= IDX_W'(qry_len - DATA_W'(1));
		end else if (busy) begin
			row_buf[j_idx] <= cell_cost;
			if (j_idx == ref_last) begin
				// New row, left and diagonal fall outside
				j_idx     <= '0;
				i_idx     <= i_idx + 1'b1;
				left_cost <= DIST_MAX;
				diag_cost <= DIST_MAX;
			end else begin
				j_idx     <= j_idx + 1'b1;
				left_cost <= cell_cost;
				// Above of this cell is diagonal of the next
				diag_cost <= up_cost;
			end
		end
	end

	// Status flags and result
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			busy     <= 1'b0;
			done     <= 1'b0;
			err      <= 1'b0;
			distance <= '0;
		end else begin
			if (busy && last_cell) begin
				busy     <= 1'b0;
				done     <= 1'b1;
				distance <= cell_cost;
			end
			if (launch) begin
				distance <= '0;
				if (len_ok) begin
					busy <= 1'b1;
					done <= 1'b0;
					err  <= 1'b0;
				end else begin
					// Bad length, finish at once with error
					done <= 1'b1;
					err  <= 1'b1;
				end
			end
			if (clear) begin
				done     <= 1'b0;
				err      <= 1'b0;
				distance <= '0;
			end
		end
	end

endmodule

`default_nettype wire

/* dtw_accel_top.sv */
`default_nettype none

module dtw_accel_top import dtw_pkg::*; #(
	parameter int MAX_LEN = DEF_MAX_LEN
) (
	input  logic                S_AXI_ACLK,
	input  logic                S_AXI_ARESETN,
	input  logic [ADDR_W-1:0]   S_AXI_AWADDR,
	input  logic [2:0]          S_AXI_AWPROT,
	input  logic                S_AXI_AWVALID,
	output logic                S_AXI_AWREADY,
	input  logic [DATA_W-1:0]   S_AXI_WDATA,
	input  logic [DATA_W/8-1:0] S_AXI_WSTRB,
	input  logic                S_AXI_WVALID,
	output logic                S_AXI_WREADY,
	output logic [1:0]          S_AXI_BRESP,
	output logic                S_AXI_BVALID,
	input  logic                S_AXI_BREADY,
	input  logic [ADDR_W-1:0]   S_AXI_ARADDR,
	input  logic [2:0]          S_AXI_ARPROT,
	input  logic                S_AXI_ARVALID,
	output logic                S_AXI_ARREADY,
	output logic [DATA_W-1:0]   S_AXI_RDATA,
	output logic [1:0]          S_AXI_RRESP,
	output logic                S_AXI_RVALID,
	input  logic                S_AXI_RREADY
);

	localparam int IDX_W = (MAX_LEN > 1) ? $clog2(MAX_LEN) : 1;

	// Register slave to buffers and core
	logic                start;
	logic                clear;
	logic                ref_push;
	logic                qry_push;
	logic [SAMPLE_W-1:0] push_data;
	logic [DATA_W-1:0]   ref_len;
	logic [DATA_W-1:0]   qry_len;
	// Core back to slave
	logic                busy;
	logic                done;
	logic                err;
	logic [DIST_W-1:0]   distance;
	// Core sample fetch
	logic [IDX_W-1:0]    ref_rd_addr;
	logic [IDX_W-1:0]    qry_rd_addr;
	logic [SAMPLE_W-1:0] ref_sample;
	logic [SAMPLE_W-1:0] qry_sample;

	dtw_axi_regs #(.MAX_LEN(MAX_LEN)) i_regs (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.S_AXI_AWADDR, .S_AXI_AWPROT, .S_AXI_AWVALID, .S_AXI_AWREADY,
		.S_AXI_WDATA, .S_AXI_WSTRB, .S_AXI_WVALID, .S_AXI_WREADY,
		.S_AXI_BRESP, .S_AXI_BVALID, .S_AXI_BREADY,
		.S_AXI_ARADDR, .S_AXI_ARPROT, .S_AXI_ARVALID, .S_AXI_ARREADY,
		.S_AXI_RDATA, .S_AXI_RRESP, .S_AXI_RVALID, .S_AXI_RREADY,
		.busy, .done, .err, .distance,
		.start, .clear, .ref_push, .qry_push, .push_data, .ref_len, .qry_len
	);

	// Reference samples
	dtw_sample_buf #(.MAX_LEN(MAX_LEN)) i_ref_buf (
		.S_AXI_ACLK, .S_AXI_ARESETN, .clear,
		.push(ref_push), .push_data,
		.rd_addr(ref_rd_addr), .rd_sample(ref_sample)
	);

	// Query samples
	dtw_sample_buf #(.MAX_LEN(MAX_LEN)) i_qry_buf (
		.S_AXI_ACLK, .S_AXI_ARESETN, .clear,
		.push(qry_push), .push_data,
		.rd_addr(qry_rd_addr), .rd_sample(qry_sample)
	);

	dtw_core #(.MAX_LEN(MAX_LEN)) i_core (
		.S_AXI_ACLK, .S_AXI_ARESETN, .start, .clear,
		.ref_len, .qry_len, .ref_sample, .qry_sample,
		.ref_rd_addr, .qry_rd_addr,
		.busy, .done, .err, .distance
	);

endmodule

`default_nettype wire

/* dtw_accel_asserts.sv */
`default_nettype none

module dtw_accel_asserts #(
	parameter int DATA_W = 32
) (
	input logic              S_AXI_ACLK,
	input logic              S_AXI_ARESETN,
	input logic              S_AXI_BVALID,
	input logic              S_AXI_BREADY,
	input logic              S_AXI_RVALID,
	input logic              S_AXI_RREADY,
	input logic [DATA_W-1:0] S_AXI_RDATA,
	input logic              busy,
	input logic              done,
	input logic              err
);

	timeunit 1ns;
	timeprecision 1ps;

	// Failures seen so far, read by the testbench top
	int fail_count = 0;

	// ----------------------------------------
	// AXI response channels
	// ----------------------------------------
	property hold_until_ready(valid, ready);
		@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		valid && !ready |=> valid;
	endproperty

	a_bvalid_hold: assert property (hold_until_ready(S_AXI_BVALID, S_AXI_BREADY))
		else begin
			$error("BVALID dropped before BREADY");
			fail_count++;
		end

	a_rvalid_hold: assert property (hold_until_ready(S_AXI_RVALID, S_AXI_RREADY))
		else begin
			$error("RVALID dropped before RREADY");
			fail_count++;
		end

	// Read data frozen while the master stalls
	a_rdata_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_RVALID && !S_AXI_RREADY |=> $stable(S_AXI_RDATA))
		else begin
			$error("RDATA changed while RVALID waited");
			fail_count++;
		end

	// ----------------------------------------
	// Core status flags
	// ----------------------------------------
	a_busy_done: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		!(busy && done))
		else begin
			$error("busy and done high together");
			fail_count++;
		end

	a_busy_err: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		!(busy && err))
		else begin
			$error("busy high while err is set");
			fail_count++;
		end

endmodule

// Attached to every instance of the accelerator top
bind dtw_accel_top dtw_accel_asserts #(.DATA_W(DATA_W)) i_asserts (
	.S_AXI_ACLK, .S_AXI_ARESETN,
	.S_AXI_BVALID, .S_AXI_BREADY,
	.S_AXI_RVALID, .S_AXI_RREADY, .S_AXI_RDATA,
	.busy, .done, .err
);

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
	parameter real PERIOD_NS    = 8.0,
	parameter int  RESET_CYCLES = 2
) (
	output logic S_AXI_ACLK,
	output logic S_AXI_ARESETN
);

	timeunit 1ns;
	timeprecision 1ps;

	// Free running clock, first rising edge half a period in
	initial begin
		S_AXI_ACLK = 1'b0;
		forever #(PERIOD_NS / 2.0) S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// Synchronous reset, low for a fixed number of edges
	initial begin
		S_AXI_ARESETN = 1'b0;
		repeat (RESET_CYCLES) @(posedge S_AXI_ACLK);
		S_AXI_ARESETN <= 1'b1;
	end

endmodule

`default_nettype wire

/* tb_dtw_accel.sv */
`default_nettype none

module tb_dtw_accel import dtw_pkg::*;;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_LEN    = DEF_MAX_LEN;
	// Cycles any single handshake may take
	localparam int WAIT_LIMIT = 100;
	// Status reads before giving up on done
	localparam int POLL_LIMIT = 200;
	// Outside-the-matrix cost for the model
	localparam int BIG        = 32'h0FFF_FFFF;
	// AXI response code for a good transfer
	localparam logic [1:0] RESP_OKAY = 2'b00;

	logic                S_AXI_ACLK;
	logic                S_AXI_ARESETN;
	logic [ADDR_W-1:0]   S_AXI_AWADDR;
	logic [2:0]          S_AXI_AWPROT;
	logic                S_AXI_AWVALID;
	logic                S_AXI_AWREADY;
	logic [DATA_W-1:0]   S_AXI_WDATA;
	logic [DATA_W/8-1:0] S_AXI_WSTRB;
	logic                S_AXI_WVALID;
	logic                S_AXI_WREADY;
	logic [1:0]          S_AXI_BRESP;
	logic                S_AXI_BVALID;
	logic                S_AXI_BREADY;
	logic [ADDR_W-1:0]   S_AXI_ARADDR;
	logic [2:0]          S_AXI_ARPROT;
	logic                S_AXI_ARVALID;
	logic                S_AXI_ARREADY;
	logic [DATA_W-1:0]   S_AXI_RDATA;
	logic [1:0]          S_AXI_RRESP;
	logic                S_AXI_RVALID;
	logic                S_AXI_RREADY;

	int seed;
	int errors;
	int checks;
	int timeouts;
	// Longest random BREADY/RREADY stall
	// Zero turns stalls off
	int max_stall;
	// Samples as pushed for the model
	int ref_s [MAX_LEN];
	int qry_s [MAX_LEN];

	tb_clock_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(2)) i_clk (
		.S_AXI_ACLK, .S_AXI_ARESETN
	);

	dtw_accel_top #(.MAX_LEN(MAX_LEN)) i_dut (.*);

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	function automatic logic [ADDR_W-1:0] reg_addr(input logic [REG_IDX_W-1:0] idx);
		return ADDR_W'(idx) << ADDR_LSB;
	endfunction

	function automatic int draw_stall();
		if (max_stall == 0)
			return 0;
		return ($random(seed) & 32'h7FFF_FFFF) % (max_stall + 1);
	endfunction

	// Full-matrix DTW
	// Row 0 and column 0 form the outside border
	function automatic int model_distance(input int rlen, input int qlen);
		int cost [MAX_LEN+1][MAX_LEN+1];
		int best;
		int diff;
		for (int i = 0; i <= qlen; i++)
			for (int j = 0; j <= rlen; j++)
				cost[i][j] = BIG;
		cost[0][0] = 0;
		for (int i = 1; i <= qlen; i++) begin
			for (int j = 1; j <= rlen; j++) begin
				diff = ref_s[j-1] - qry_s[i-1];
				if (diff < 0)
					diff = -diff;
				best = cost[i-1][j];
				if (cost[i][j-1] < best)
					best = cost[i][j-1];
				if (cost[i-1][j-1] < best)
					best = cost[i-1][j-1];
				cost[i][j] = best + diff;
			end
		end
		return cost[qlen][rlen];
	endfunction

	task automatic report_timeout(input string what);
		$display("Timeout at %0t ns: %s", $time, what);
		timeouts++;
	endtask

	// Both response channels always answer OKAY
	task automatic check_resp(input string name, input logic [1:0] resp);
		checks++;
		assert (resp === RESP_OKAY) else begin
			$display("error at %0t ns: %s expected 0x%0h, got 0x%0h",
				$time, name, RESP_OKAY, resp);
			errors++;
		end
	endtask

	// ----------------------------------------
	// AXI4-Lite master tasks
	// ----------------------------------------
	task automatic axi_write(input logic [REG_IDX_W-1:0] idx, input logic [DATA_W-1:0] data,
			input logic [DATA_W/8-1:0] strb);
		int cnt;
		int stall;
		stall = draw_stall();
		@(posedge S_AXI_ACLK);
		S_AXI_AWADDR  <= reg_addr(idx);
		S_AXI_AWVALID <= 1'b1;
		S_AXI_WDATA   <= data;
		S_AXI_WSTRB   <= strb;
		S_AXI_WVALID  <= 1'b1;
		cnt = 0;
		do begin
			@(posedge S_AXI_ACLK);
			cnt++;
		end while (!(S_AXI_AWREADY && S_AXI_WREADY) && cnt < WAIT_LIMIT);
		S_AXI_AWVALID <= 1'b0;
		S_AXI_WVALID  <= 1'b0;
		if (!(S_AXI_AWREADY && S_AXI_WREADY))
			report_timeout("write address and data never accepted");
		// Hold off the response for a while
		repeat (stall) @(posedge S_AXI_ACLK);
		S_AXI_BREADY <= 1'b1;
		cnt = 0;
		do begin
			@(posedge S_AXI_ACLK);
			cnt++;
		end while (!S_AXI_BVALID && cnt < WAIT_LIMIT);
		S_AXI_BREADY <= 1'b0;
		if (!S_AXI_BVALID)
			report_timeout("write response never arrived");
		else
			check_resp("S_AXI_BRESP", S_AXI_BRESP);
	endtask

	task automatic axi_read(input logic [REG_IDX_W-1:0] idx, output logic [DATA_W-1:0] data);
		int cnt;
		int stall;
		stall = draw_stall();
		@(posedge S_AXI_ACLK);
		S_AXI_ARADDR  <= reg_addr(idx);
		S_AXI_ARVALID <= 1'b1;
		cnt = 0;
		do begin
			@(posedge S_AXI_ACLK);
			cnt++;
		end while (!S_AXI_ARREADY && cnt < WAIT_LIMIT);
		S_AXI_ARVALID <= 1'b0;
		if (!S_AXI_ARREADY)
			report_timeout("read address never accepted");
		repeat (stall) @(posedge S_AXI_ACLK);
		S_AXI_RREADY <= 1'b1;
		cnt = 0;
		do begin
			@(posedge S_AXI_ACLK);
			cnt++;
		end while (!S_AXI_RVALID && cnt < WAIT_LIMIT);
		// Values before the edge give the handshake data
		data = S_AXI_RDATA;
		S_AXI_RREADY <= 1'b0;
		if (!S_AXI_RVALID)
			report_timeout("read data never arrived");
		else
			check_resp("S_AXI_RRESP", S_AXI_RRESP);
	endtask

	task automatic check_reg(input string name, input logic [REG_IDX_W-1:0] idx,
			input logic [DATA_W-1:0] expected);
		logic [DATA_W-1:0] got;
		axi_read(idx, got);
		checks++;
		assert (got === expected) else begin
			$display("error at %0t ns: %s expected 0x%08h, got 0x%08h",
				$time, name, expected, got);
			errors++;
		end
	endtask

	// ----------------------------------------
	// Accelerator sequences
	// ----------------------------------------
	task automatic clear_core();
		axi_write(REG_CTRL, DATA_W'(1) << CTRL_CLEAR_BIT, 4'hF);
	endtask

	task automatic start_core();
		axi_write(REG_CTRL, DATA_W'(1) << CTRL_START_BIT, 4'hF);
	endtask

	task automatic wait_done();
		logic [DATA_W-1:0] st;
		int polls;
		polls = 0;
		do begin
			axi_read(REG_STATUS, st);
			polls++;
		end while (!st[STAT_DONE_BIT] && polls < POLL_LIMIT);
		if (!st[STAT_DONE_BIT])
			report_timeout("core never raised done");
	endtask

	// Lengths set and run on the samples already buffered
	task automatic start_and_check(input int rlen, input int qlen);
		int exp_dist;
		axi_write(REG_REF_LEN, DATA_W'(rlen), 4'hF);
		axi_write(REG_QRY_LEN, DATA_W'(qlen), 4'hF);
		exp_dist = model_distance(rlen, qlen);
		start_core();
		wait_done();
		check_reg("REG_STATUS", REG_STATUS, DATA_W'(1) << STAT_DONE_BIT);
		check_reg("REG_DIST", REG_DIST, DATA_W'(exp_dist));
		check_reg("REG_CTRL", REG_CTRL, '0);
	endtask

	// Push fresh samples and run them against the model
	task automatic run_dtw(input int rlen, input int qlen);
		for (int k = 0; k < rlen; k++) begin
			ref_s[k] = $random(seed) & 32'hFF;
			// Junk in the upper bytes is ignored
			axi_write(REG_REF_PUSH, 32'hA5C3_9600 | DATA_W'(ref_s[k]), 4'b0001);
		end
		for (int k = 0; k < qlen; k++) begin
			qry_s[k] = $random(seed) & 32'hFF;
			axi_write(REG_QRY_PUSH, 32'h5A3C_6900 | DATA_W'(qry_s[k]), 4'b0001);
		end
		start_and_check(rlen, qlen);
	endtask

	// Bad length gives done and err with zero distance
	task automatic run_bad_len(input int rlen, input int qlen);
		axi_write(REG_REF_LEN, DATA_W'(rlen), 4'hF);
		axi_write(REG_QRY_LEN, DATA_W'(qlen), 4'hF);
		start_core();
		wait_done();
		check_reg("REG_STATUS", REG_STATUS,
			(DATA_W'(1) << STAT_DONE_BIT) | (DATA_W'(1) << STAT_ERR_BIT));
		check_reg("REG_DIST", REG_DIST, '0);
	endtask

	function automatic int rand_len();
		return (($random(seed) & 32'h7FFF_FFFF) % MAX_LEN) + 1;
	endfunction

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------
	initial begin : stimulus
		int cnt;
		seed      = 27660;
		errors    = 0;
		checks    = 0;
		timeouts  = 0;
		max_stall = 0;
		S_AXI_AWADDR  <= '0;
		S_AXI_AWPROT  <= 3'b000;
		S_AXI_AWVALID <= 1'b0;
		S_AXI_WDATA   <= '0;
		S_AXI_WSTRB   <= '0;
		S_AXI_WVALID  <= 1'b0;
		S_AXI_BREADY  <= 1'b0;
		S_AXI_ARADDR  <= '0;
		S_AXI_ARPROT  <= 3'b000;
		S_AXI_ARVALID <= 1'b0;
		S_AXI_RREADY  <= 1'b0;

		cnt = 0;
		do begin
			@(posedge S_AXI_ACLK);
			cnt++;
		end while (!S_AXI_ARESETN && cnt < WAIT_LIMIT);
		if (!S_AXI_ARESETN)
			report_timeout("reset never released");

		// Reset values
		check_reg("REG_REF_LEN", REG_REF_LEN, DATA_W'(MAX_LEN));
		check_reg("REG_QRY_LEN", REG_QRY_LEN, DATA_W'(MAX_LEN));
		check_reg("REG_STATUS", REG_STATUS, '0);
		check_reg("REG_CTRL", REG_CTRL, '0);

		// Partial byte strobes touch only their lanes
		axi_write(REG_REF_LEN, 32'hA5A5_0700, 4'b0010);
		check_reg("REG_REF_LEN", REG_REF_LEN, 32'h0000_0700 | DATA_W'(MAX_LEN));
		axi_write(REG_QRY_LEN, 32'h0033_2203, 4'b0101);
		check_reg("REG_QRY_LEN", REG_QRY_LEN, 32'h0033_0003);
		axi_write(3'd7, 32'hFFFF_FFFF, 4'hF);
		check_reg("reserved register", 3'd7, '0);
		check_reg("REG_REF_PUSH", REG_REF_PUSH, '0);
		check_reg("REG_QRY_PUSH", REG_QRY_PUSH, '0);

		// Random sequence pairs and then both buffers full
		for (int n = 0; n < 6; n++) begin
			clear_core();
			run_dtw(rand_len(), rand_len());
		end
		clear_core();
		run_dtw(MAX_LEN, MAX_LEN);

		// Zero length right after a good run
		run_bad_len(0, 4);

		// Clear drops the flags and old samples
		clear_core();
		check_reg("REG_STATUS", REG_STATUS, '0);
		for (int k = 0; k < 3; k++) begin
			axi_write(REG_REF_PUSH, 32'h0000_00FF, 4'b0001);
			axi_write(REG_QRY_PUSH, 32'h0000_0000, 4'b0001);
		end
		clear_core();
		run_dtw(5, 7);

		// One past the buffer depth
		run_bad_len(3, MAX_LEN + 1);
		// Good lengths again while err is still set
		start_and_check(5, 7);
		clear_core();
		check_reg("REG_STATUS", REG_STATUS, '0);

		// Stalled response channels
		max_stall = 6;
		axi_write(REG_REF_LEN, 32'h0000_1234, 4'b0011);
		check_reg("REG_REF_LEN", REG_REF_LEN, 32'h0000_1234);
		for (int n = 0; n < 3; n++) begin
			clear_core();
			run_dtw(rand_len(), rand_len());
		end
		max_stall = 0;

		repeat (4) @(posedge S_AXI_ACLK);
		$display("Checks: %0d, errors: %0d, assertion failures: %0d, timeouts: %0d",
			checks, errors, i_dut.i_asserts.fail_count, timeouts);
		if (errors == 0 && timeouts == 0 && i_dut.i_asserts.fail_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
dtw_pkg.sv
dtw_axi_regs.sv
dtw_sample_buf.sv
dtw_core.sv
dtw_accel_top.sv
dtw_accel_asserts.sv
tb_clock_gen.sv
tb_dtw_accel.sv
